//--- verilog/bumpyPkg.sv
`default_nettype none

package bumpyPkg;

	localparam int MAP_DIM = 16;             // tiles per side
	localparam int JUMP_HEIGHT = 3;          // tiles risen per jump
	localparam int SYNC_STAGES = 2;
	localparam logic [1:0] START_LIVES = 2'd3;

	typedef enum logic [2:0] {
		FREE  = 3'b000,
		REGU  = 3'b001,
		GATE  = 3'b010,
		DEATH = 3'b011,
		WALL  = 3'b100
	} tileType;

	typedef enum logic [3:0] {
		sReset, sIdle, sLeft, sRight, sDown, sUp, sDie,
		sBounceLeft, sBounceRight, sBounceTop, sDownRight, sDownLeft
	} bumpyState;

	typedef logic [3:0] edgeCode;            // one-hot {left, top, right, bottom}

	localparam edgeCode EDGE_BOTTOM = 4'b0001;
	localparam edgeCode EDGE_RIGHT  = 4'b0010;
	localparam edgeCode EDGE_TOP    = 4'b0100;
	localparam edgeCode EDGE_LEFT   = 4'b1000;
	localparam edgeCode EDGE_ALL    = 4'b1111; // ball taken off the board on restart

	typedef struct packed {
		logic up;
		logic left;
		logic right;
		logic down;
	} keysT;

	typedef struct packed {
		logic [3:0] x;
		logic [3:0] y;
	} tilePos;

	localparam tilePos START_POS = '{x: 4'd7, y: 4'd0};

	typedef struct packed {
		tileType left;
		tileType up;
		tileType right;
		tileType down;
	} neighborsT;

	typedef struct packed {
		logic    landing;
		logic    apex;
		edgeCode hitEdge;
	} collisionT;

endpackage

`default_nettype wire

//--- verilog/keyDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module keyDecoder
	import bumpyPkg::*;
(
	input  logic clk,
	input  logic resetN,
	input  logic upBtn,
	input  logic leftBtn,
	input  logic rightBtn,
	input  logic downBtn,
	output keysT keys
);

	// one row per stage, bits ordered {up, left, right, down}
	logic [SYNC_STAGES-1:0][3:0] syncQ;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			syncQ <= '1; // released buttons sit high
		end else begin
			syncQ[0] <= {upBtn, leftBtn, rightBtn, downBtn};
			for (int i = 1; i < SYNC_STAGES; i++) begin
				syncQ[i] <= syncQ[i-1];
			end
		end
	end

	assign keys = keysT'(~syncQ[SYNC_STAGES-1]); // active high from here on

endmodule

`default_nettype wire

//--- verilog/tileMap.sv
`timescale 1ns/1ps
`default_nettype none

module tileMap
	import bumpyPkg::*;
(
	input  logic      clk,
	input  logic      resetN,
	input  logic      mapWrEn,
	input  tilePos    mapWrPos,
	input  tileType   mapWrTile,
	input  tilePos    pos,
	output neighborsT neighbors
);

	tileType mapMem [MAP_DIM][MAP_DIM]; // indexed [y][x]

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			for (int y = 0; y < MAP_DIM; y++) begin
				for (int x = 0; x < MAP_DIM; x++) begin
					mapMem[y][x] <= FREE; // empty level
				end
			end
		end else if (mapWrEn) begin
			mapMem[mapWrPos.y][mapWrPos.x] <= mapWrTile;
		end
	end

	// anything outside the grid behaves as a wall
	function automatic tileType tileAt(input int x, input int y);
		tileType t;
		if (x < 0 || x >= MAP_DIM || y < 0 || y >= MAP_DIM) begin
			t = WALL;
		end else begin
			t = mapMem[y][x];
		end
		return t;
	endfunction

	always_comb begin
		neighbors.left  = tileAt(int'(pos.x) - 1, int'(pos.y));
		neighbors.up    = tileAt(int'(pos.x), int'(pos.y) - 1);
		neighbors.right = tileAt(int'(pos.x) + 1, int'(pos.y));
		neighbors.down  = tileAt(int'(pos.x), int'(pos.y) + 1);
	end

endmodule

`default_nettype wire

//--- verilog/bumpyFsm.sv
`timescale 1ns/1ps
`default_nettype none

module bumpyFsm
	import bumpyPkg::*;
(
	input  logic      clk,
	input  logic      resetN,
	input  keysT      keys,
	input  neighborsT neighbors,
	input  collisionT collision,
	output bumpyState state
);

	bumpyState nextState;
	logic      landed;

	assign landed = collision.landing && (collision.hitEdge == EDGE_BOTTOM);

	// key priority is up, then left, then right
	function automatic bumpyState chooseMove(input keysT k, input neighborsT n);
		bumpyState move;
		if (k.up) begin
			if (n.up == WALL || n.up == REGU) begin
				move = sBounceTop; // head against a solid tile
			end else begin
				move = sUp;
			end
		end else if (k.left) begin
			if (n.left == WALL) begin
				move = sBounceLeft;
			end else if (n.left == FREE) begin
				move = sDownLeft;
			end else begin
				move = sLeft;
			end
		end else if (k.right) begin
			if (n.right == WALL) begin
				move = sBounceRight;
			end else if (n.right == FREE) begin
				move = sDownRight;
			end else begin
				move = sRight;
			end
		end else begin
			move = sIdle;
		end
		return move;
	endfunction

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state <= sReset;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state; // hold unless something happens
		case (state)
			sReset: begin
				if (|keys) begin
					nextState = sDown; // any key drops the ball in
				end
			end
			sDown: begin
				if (neighbors.down == DEATH) begin
					nextState = sDie;
				end else if (landed) begin
					nextState = chooseMove(keys, neighbors);
				end
			end
			sUp: begin
				if (collision.apex) begin
					nextState = chooseMove(keys, neighbors); // decide only at the top
				end
			end
			sIdle, sLeft, sRight, sBounceLeft, sBounceRight, sBounceTop,
			sDownLeft, sDownRight: begin
				if (landed) begin
					nextState = chooseMove(keys, neighbors);
				end
			end
			sDie: begin
				if (collision.hitEdge == EDGE_ALL) begin
					nextState = sReset; // ball is back at the start
				end
			end
			default: begin
				nextState = sReset;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/bumpyMotion.sv
`timescale 1ns/1ps
`default_nettype none

module bumpyMotion
	import bumpyPkg::*;
(
	input  logic       clk,
	input  logic       resetN,
	input  logic       frameTick,
	input  bumpyState  state,
	input  neighborsT  neighbors,
	output tilePos     pos,
	output collisionT  collision,
	output logic [1:0] lives,
	output logic       gameOver
);

	logic [$clog2(JUMP_HEIGHT+1)-1:0] riseCnt; // tiles risen in this jump
	logic stepLeft;
	logic stepRight;
	logic stepUp;
	logic stepDown;
	logic falling;
	logic landing;
	logic reachedTop;

	always_comb begin
		falling = state inside {sDown, sBounceLeft, sBounceRight, sBounceTop,
			sDownLeft, sDownRight};
		stepLeft  = (state inside {sLeft, sDownLeft}) && (neighbors.left != WALL);
		stepRight = (state inside {sRight, sDownRight}) && (neighbors.right != WALL);
		stepDown  = falling && (neighbors.down == FREE);
		stepUp    = (state == sUp) && (neighbors.up != WALL) && (neighbors.up != REGU);
		// a resting idle ball keeps reporting ground contact
		landing   = (falling || (state inside {sLeft, sRight, sIdle}))
			&& (neighbors.down != FREE);
		// blocked head ends the jump early
		reachedTop = !stepUp || (riseCnt == JUMP_HEIGHT - 1);
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			pos       <= START_POS;
			collision <= '0;
			lives     <= START_LIVES;
			gameOver  <= 1'b0;
			riseCnt   <= '0;
		end else begin
			collision <= '0; // reports are single-cycle pulses
			if (state != sUp) begin
				riseCnt <= '0;
			end
			if (frameTick && !gameOver) begin
				if (state == sDie) begin
					lives             <= lives - 2'd1;
					gameOver          <= (lives == 2'd1); // last life gone
					pos               <= START_POS;
					collision.hitEdge <= EDGE_ALL;
				end else begin
					if (stepLeft) begin
						pos.x <= pos.x - 4'd1;
					end else if (stepRight) begin
						pos.x <= pos.x + 4'd1;
					end
					if (stepUp) begin
						pos.y <= pos.y - 4'd1;
					end else if (stepDown) begin
						pos.y <= pos.y + 4'd1;
					end
					if (landing) begin
						collision.landing <= 1'b1;
						collision.hitEdge <= EDGE_BOTTOM;
					end
					if (state == sUp) begin
						riseCnt        <= reachedTop ? '0 : riseCnt + 1'b1;
						collision.apex <= reachedTop;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/bumpyTop.sv
`timescale 1ns/1ps
`default_nettype none

module bumpyTop
	import bumpyPkg::*;
(
	input  logic       clk,
	input  logic       resetN,
	input  logic       upBtn,
	input  logic       leftBtn,
	input  logic       rightBtn,
	input  logic       downBtn,
	input  logic       frameTick,
	input  logic       mapWrEn,
	input  tilePos     mapWrPos,
	input  tileType    mapWrTile,
	output tilePos     pos,
	output bumpyState  state,
	output logic [1:0] lives,
	output logic       gameOver
);

	keysT      keys;
	neighborsT neighbors; // tiles around the current position
	collisionT collision;

	keyDecoder keyDecoder_inst (
		.clk      (clk),
		.resetN   (resetN),
		.upBtn    (upBtn),
		.leftBtn  (leftBtn),
		.rightBtn (rightBtn),
		.downBtn  (downBtn),
		.keys     (keys)
	);

	tileMap tileMap_inst (
		.clk       (clk),
		.resetN    (resetN),
		.mapWrEn   (mapWrEn),
		.mapWrPos  (mapWrPos),
		.mapWrTile (mapWrTile),
		.pos       (pos),
		.neighbors (neighbors)
	);

	bumpyFsm bumpyFsm_inst (
		.clk       (clk),
		.resetN    (resetN),
		.keys      (keys),
		.neighbors (neighbors),
		.collision (collision),
		.state     (state)
	);

	bumpyMotion bumpyMotion_inst (
		.clk       (clk),
		.resetN    (resetN),
		.frameTick (frameTick),
		.state     (state),
		.neighbors (neighbors),
		.pos       (pos),
		.collision (collision),
		.lives     (lives),
		.gameOver  (gameOver)
	);

endmodule

`default_nettype wire

//--- dv/bumpyTbTasks.svh
`ifndef BUMPY_TB_TASKS_SVH
`define BUMPY_TB_TASKS_SVH

task automatic failRun(input string why);
	$display("%s", why);
	$display("Test failed");
	$fatal(1, "stopping at the first error");
endtask

task automatic checkPos(input tilePos exp);
	if (pos !== exp) begin
		failRun($sformatf("error at %0t ns: pos expected (%0d,%0d) got (%0d,%0d)",
			$time, exp.x, exp.y, pos.x, pos.y));
	end
endtask

task automatic checkState(input bumpyState exp);
	if (state !== exp) begin
		failRun($sformatf("error at %0t ns: state expected %s got %s",
			$time, exp.name(), state.name()));
	end
endtask

task automatic checkLives(input logic [1:0] exp);
	if (lives !== exp) begin
		failRun($sformatf("error at %0t ns: lives expected %0d got %0d", $time, exp, lives));
	end
endtask

task automatic checkGameOver(input logic exp);
	if (gameOver !== exp) begin
		failRun($sformatf("error at %0t ns: gameOver expected %0b got %0b",
			$time, exp, gameOver));
	end
endtask

function automatic tilePos posAt(input int x, input int y);
	tilePos p;
	p.x = 4'(x);
	p.y = 4'(y);
	return p;
endfunction

task automatic step(input int n);
	repeat (n) @(posedge clk);
	#(DRIVE_DELAY); // drive just after the edge
endtask

// one frame, plus a cycle for the FSM to take the collision
task automatic tick();
	frameTick = 1'b1;
	step(1);
	frameTick = 1'b0;
	step(1);
endtask

task automatic ticks(input int n);
	repeat (n) tick();
endtask

task automatic pressKeys(input keysT k);
	{upBtn, leftBtn, rightBtn, downBtn} = ~k; // buttons are active low
endtask

task automatic restart();
	pressKeys(KEY_NONE);
	resetN = 1'b0;
	step(3);
	resetN = 1'b1;
endtask

task automatic writeTile(input tilePos p, input tileType t);
	mapWrPos  = p;
	mapWrTile = t;
	mapWrEn   = 1'b1;
	step(1);
	mapWrEn   = 1'b0;
endtask

task automatic writeFloor(input int y);
	for (int x = 0; x < MAP_DIM; x++) begin
		writeTile(posAt(x, y), REGU);
	end
endtask

// ball falls from the start tile onto a floor at row 5
task automatic dropToFloor(input keysT k);
	restart();
	writeFloor(5);
	pressKeys(k);
	step(3);
	checkState(sDown);
	ticks(4);
	checkPos(posAt(START_POS.x, 4));
endtask

task automatic testResetStart();
	restart();
	checkState(sReset);
	checkPos(START_POS);
	checkLives(START_LIVES);
	checkGameOver(1'b0);
	pressKeys(KEY_DOWN);
	step(2);
	checkState(sReset); // key still in the synchronizer
	step(1);
	checkState(sDown);
	checkGameOver(1'b0);
endtask

task automatic testFallAndLand();
	dropToFloor(KEY_DOWN);
	pressKeys(KEY_LEFT);
	step(2);
	tick();
	checkState(sDownLeft); // open tile on the left
	tick();
	checkPos(posAt(6, 4));
endtask

task automatic testWallBounce();
	dropToFloor(KEY_LEFT);
	writeTile(posAt(6, 4), WALL);
	tick();
	checkState(sBounceLeft);
	tick();
	checkPos(posAt(7, 4)); // refused move
	checkState(sBounceLeft);
endtask

task automatic testJump();
	dropToFloor(KEY_UP);
	tick();
	checkState(sUp);
	tick();
	checkPos(posAt(7, 3));
	pressKeys(KEY_LEFT); // picked up at the apex
	step(2);
	ticks(JUMP_HEIGHT - 1);
	checkPos(posAt(7, 4 - JUMP_HEIGHT));
	checkState(sDownLeft);
	dropToFloor(KEY_UP);
	writeTile(posAt(7, 3), REGU);
	tick();
	checkState(sBounceTop);
endtask

task automatic testDeath();
	restart();
	writeTile(posAt(7, 5), DEATH);
	pressKeys(KEY_DOWN);
	step(3);
	checkState(sDown);
	for (int i = 1; i <= START_LIVES; i++) begin
		ticks(4);
		checkPos(posAt(7, 4));
		checkState(sDie);
		tick();
		checkLives(2'(START_LIVES - i));
		checkPos(START_POS);
		checkState(sReset);
		step(1);
		checkState(sDown); // down still held
	end
	checkGameOver(1'b1);
	tick();
	checkPos(START_POS); // frozen after game over
endtask

task automatic testMapEdge();
	int wx;
	restart();
	writeFloor(1);
	repeat (8) begin
		wx = int'($urandom % MAP_DIM);
		writeTile(posAt(wx, 1), WALL); // walls in the floor still carry the ball
	end
	pressKeys(KEY_LEFT);
	step(3);
	checkState(sDown);
	tick();
	checkState(sDownLeft);
	for (int x = START_POS.x - 1; x >= 0; x--) begin
		tick();
		checkPos(posAt(x, 0));
	end
	checkState(sBounceLeft); // off-map tile reads as wall
	tick();
	checkPos(posAt(0, 0));
endtask

`endif

//--- dv/tbBumpyTop.sv
`timescale 1ns/1ps
`default_nettype none

module tbBumpyTop
	import bumpyPkg::*;
();

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DELAY = 10;
	localparam int TOTAL_TICKS = 50;   // frame ticks over all tests
	localparam keysT KEY_NONE = keysT'(4'b0000);
	localparam keysT KEY_UP   = keysT'(4'b1000);
	localparam keysT KEY_LEFT = keysT'(4'b0100);
	localparam keysT KEY_DOWN = keysT'(4'b0001);

	logic       clk;
	logic       resetN;
	logic       upBtn;
	logic       leftBtn;
	logic       rightBtn;
	logic       downBtn;
	logic       frameTick;
	logic       mapWrEn;
	tilePos     mapWrPos;
	tileType    mapWrTile;
	tilePos     pos;
	bumpyState  state;
	logic [1:0] lives;
	logic       gameOver;

	always #(CLK_PERIOD / 2) clk = ~clk;

	bumpyTop bumpyTop_inst (
		.clk       (clk),
		.resetN    (resetN),
		.upBtn     (upBtn),
		.leftBtn   (leftBtn),
		.rightBtn  (rightBtn),
		.downBtn   (downBtn),
		.frameTick (frameTick),
		.mapWrEn   (mapWrEn),
		.mapWrPos  (mapWrPos),
		.mapWrTile (mapWrTile),
		.pos       (pos),
		.state     (state),
		.lives     (lives),
		.gameOver  (gameOver)
	);

	`include "bumpyTbTasks.svh"

	initial begin
		#(TOTAL_TICKS * 20 * CLK_PERIOD);
		failRun("the tests did not finish before the watchdog ran out");
	end

	initial begin
		void'($urandom(46678));
		clk       = 1'b0;
		resetN    = 1'b0;
		upBtn     = 1'b1; // released
		leftBtn   = 1'b1;
		rightBtn  = 1'b1;
		downBtn   = 1'b1;
		frameTick = 1'b0;
		mapWrEn   = 1'b0;
		mapWrPos  = '0;
		mapWrTile = FREE;
		testResetStart();
		testFallAndLand();
		testWallBounce();
		testJump();
		testDeath();
		testMapEdge();
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+dv
verilog/bumpyPkg.sv
verilog/keyDecoder.sv
verilog/tileMap.sv
verilog/bumpyFsm.sv
verilog/bumpyMotion.sv
verilog/bumpyTop.sv
dv/tbBumpyTop.sv

//--- Bender.yml
package:
  name: bumpy

sources:
  - verilog/bumpyPkg.sv
  - verilog/keyDecoder.sv
  - verilog/tileMap.sv
  - verilog/bumpyFsm.sv
  - verilog/bumpyMotion.sv
  - verilog/bumpyTop.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tbBumpyTop.sv
